// File: include/sdram_config.svh
// Address split and SDRAM timing constants, included by the package and the RTL
`ifndef SDRAM_CONFIG_SVH
`define SDRAM_CONFIG_SVH

// Request word address, row on top and column below
`define SDRAM_AW        22
`define SDRAM_ROW_W     13
`define SDRAM_COL_W     9

// ACTIVE to READ/WRITE, in cycles
`define SDRAM_TRCD      2

// CAS latency, also written into the mode register
`define SDRAM_CL        2

// Auto-precharge to next ACTIVE in the same bank
`define SDRAM_TRP       2

// Power-up wait and refresh spacing during init
// Short value for simulation, real parts want about 100 us
`define SDRAM_INIT_WAIT 20

`endif

// File: run_sim.sh
#!/bin/bash
# Build and run the SDRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module sdram_tb \
    --Mdir obj_dir -o sdram_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sdram_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0

// File: tb/sdram_model.sv
// Behavioral two-bank SDR SDRAM for the testbench, CL 2, burst 2, checks command order
`timescale 1ns/1ns
`include "sdram_config.svh"

module sdram_model (
    input  logic        clk,
    inout  wire  [15:0] dq,
    input  logic [12:0] a,
    input  logic [1:0]  ba,
    input  logic        dqml,
    input  logic        dqmh,
    input  logic        ncs,
    input  logic        nras,
    input  logic        ncas,
    input  logic        nwe,
    output int          errors
);

    logic [15:0] mem [logic [23:0]];    // Key is {ba, row, col}
    logic [12:0] open_row [2];
    logic        open [2] = '{1'b0, 1'b0};
    logic [23:0] key;
    logic [23:0] rd_key1;
    logic [23:0] rd_key2;
    logic [23:0] wr_key;
    logic        rd_v1 = 1'b0;
    logic        rd_v2 = 1'b0;
    logic        wr_v = 1'b0;
    logic [15:0] dq_out = 16'h0;
    logic        dq_oe = 1'b0;
    logic [3:0]  cmd;
    int          err_cnt = 0;

    assign errors = err_cnt;
    assign cmd    = {ncs, nras, ncas, nwe};
    assign dq     = dq_oe ? dq_out : 16'hzzzz;

    task automatic store(input logic [23:0] k, input logic [15:0] d, input logic [1:0] m);
        logic [15:0] old;
        old = mem.exists(k) ? mem[k] : 16'h0;
        if (!m[0]) old[7:0] = d[7:0];      // Set dqm bit keeps the byte
        if (!m[1]) old[15:8] = d[15:8];
        mem[k] = old;
    endtask

    function automatic logic [15:0] fetch(input logic [23:0] k);
        return mem.exists(k) ? mem[k] : 16'h0;
    endfunction

    always @(posedge clk) begin
        rd_v1   <= 1'b0;
        wr_v    <= 1'b0;
        rd_v2   <= rd_v1;
        rd_key2 <= rd_key1 ^ 24'd1;    // Second beat wraps inside the burst
        if (rd_v1) begin
            dq_oe  <= 1'b1;
            dq_out <= fetch(rd_key1);
        end else if (rd_v2) begin
            dq_oe  <= 1'b1;
            dq_out <= fetch(rd_key2);
        end else begin
            dq_oe <= 1'b0;
        end
        if (wr_v) store(wr_key, dq, {dqmh, dqml});
        case (cmd)
            sdram_pkg::ACTIVE: begin
                if (open[ba[0]]) begin
                    $display("ERROR %0t: ACTIVE to bank %0d while a row is open", $time, ba);
                    err_cnt <= err_cnt + 1;
                end
                open[ba[0]]     <= 1'b1;
                open_row[ba[0]] <= a;
            end
            sdram_pkg::READ, sdram_pkg::WRITE: begin
                if (!open[ba[0]]) begin
                    $display("ERROR %0t: READ/WRITE to bank %0d with no open row", $time, ba);
                    err_cnt <= err_cnt + 1;
                end
                key = {ba, open_row[ba[0]], a[8:0]};
                if (cmd == sdram_pkg::READ) begin
                    rd_v1   <= 1'b1;
                    rd_key1 <= key;
                end else begin
                    store(key, dq, {dqmh, dqml});
                    wr_v   <= 1'b1;
                    wr_key <= key ^ 24'd1;
                end
                if (a[10]) open[ba[0]] <= 1'b0;   // Auto-precharge
            end
            sdram_pkg::PRECHARGE: begin
                if (a[10]) begin
                    open[0] <= 1'b0;
                    open[1] <= 1'b0;
                end else begin
                    open[ba[0]] <= 1'b0;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: tb/sdram_sva.sv
// Protocol assertions on the controller host ports, bound into sdram_ctrl
`timescale 1ns/1ns

module sdram_sva (
    input logic       clk,
    input logic       rst,
    input logic [1:0] ack,
    input logic [1:0] dst,
    input logic [1:0] dok,
    input logic [1:0] rdy
);

    logic [1:0] pend;   // Acked and not yet done

    always_ff @(posedge clk, posedge rst) begin
        if (rst) pend <= 2'b00;
        else pend <= (pend | ack) & ~rdy;
    end

    a_ack_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ack))
        else $error("ack raised on both ports in one cycle");

    for (genvar i = 0; i < 2; i++) begin : g_port
        a_dok: assert property (@(posedge clk) disable iff (rst) dst[i] |-> dok[i] ##1 dok[i])
            else $error("dst on port %0d without dok on both beats", i);
        a_rdy: assert property (@(posedge clk) disable iff (rst) rdy[i] |-> pend[i])
            else $error("rdy on port %0d with no ack before it", i);
        a_ack: assert property (@(posedge clk) disable iff (rst) ack[i] |-> !pend[i])
            else $error("second ack on port %0d before rdy", i);
    end

endmodule

bind sdram_ctrl sdram_sva i_sva (
    .clk (clk),
    .rst (rst),
    .ack (ack),
    .dst (dst),
    .dok (dok),
    .rdy (rdy)
);

// File: tb/sdram_tb.sv
// Testbench top, runs directed and LFSR accesses through the controller and a model SDRAM
`timescale 1ns/1ns
`include "sdram_config.svh"

module sdram_tb;

    typedef struct packed {
        logic        pair;     // Start together with the next row
        logic        port;
        logic        rd;
        logic [21:0] addr;
        logic [31:0] wdata;
        logic [3:0]  mask;
    } row_t;

    localparam int N_DIR  = 9;
    localparam int N_ROWS = N_DIR + 24;
    localparam int LIMIT  = `SDRAM_INIT_WAIT * 3 + 40 * N_ROWS;
    // CAS latency in A6:4, sequential burst of 2 in A2:0, everything else zero
    localparam logic [12:0] MODE_VAL = 13'(`SDRAM_CL << 4) | 13'h001;

    logic                 clk;
    logic                 rst;
    sdram_pkg::host_req_t req [2];
    logic [1:0]           ack, dst, dok, rdy;
    logic [15:0]          dout;
    wire  [15:0]          sdram_dq;
    logic [12:0]          sdram_a;
    logic [1:0]           sdram_ba;
    logic                 sdram_dqml, sdram_dqmh;
    logic                 sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe;

    row_t        rows [N_ROWS];
    logic [31:0] ref_mem [logic [22:0]];   // Key is {port, addr}
    logic [15:0] lfsr;
    int          errors = 0;
    int          model_errors;
    int          cyc = 0;
    int          n_cmd = 0;
    int          read_cyc [2];
    logic        rd_busy [2] = '{1'b0, 1'b0};
    logic        mode_done = 1'b0;
    logic [3:0]  pcmd;
    int          idx;

    sdram_ctrl i_dut (
        .clk (clk), .rst (rst), .req0 (req[0]), .req1 (req[1]),
        .ack (ack), .dst (dst), .dok (dok), .rdy (rdy), .dout (dout),
        .sdram_dq (sdram_dq), .sdram_a (sdram_a), .sdram_ba (sdram_ba),
        .sdram_dqml (sdram_dqml), .sdram_dqmh (sdram_dqmh), .sdram_ncs (sdram_ncs),
        .sdram_nras (sdram_nras), .sdram_ncas (sdram_ncas), .sdram_nwe (sdram_nwe)
    );

    sdram_model i_model (
        .clk (clk), .dq (sdram_dq), .a (sdram_a), .ba (sdram_ba),
        .dqml (sdram_dqml), .dqmh (sdram_dqmh), .ncs (sdram_ncs),
        .nras (sdram_nras), .ncas (sdram_ncas), .nwe (sdram_nwe), .errors (model_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("Timeout, the run did not finish within %0d cycles", LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = 32'h0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Byte merge, a set mask bit keeps the old byte
    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] d,
                                          input logic [3:0] m);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (!m[b]) res[b*8 +: 8] = d[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic row_t make_row(input logic pair, input logic port, input logic rd,
                                      input logic [21:0] addr, input logic [31:0] wdata,
                                      input logic [3:0] mask);
        row_t r;
        r.pair  = pair;
        r.port  = port;
        r.rd    = rd;
        r.addr  = addr;
        r.wdata = wdata;
        r.mask  = mask;
        return r;
    endfunction

    task automatic build_rows();
        logic [31:0] v_port, v_rd, v_row, v_col, v_data, v_mask;
        rows[0] = make_row(0, 0, 0, 22'h002010, 32'h1234_5678, 4'b0000);
        rows[1] = make_row(0, 0, 1, 22'h002010, 32'h0, 4'b0000);
        rows[2] = make_row(0, 0, 0, 22'h002010, 32'hAABB_CCDD, 4'b0101);
        rows[3] = make_row(0, 0, 1, 22'h002010, 32'h0, 4'b0000);
        rows[4] = make_row(1, 0, 0, 22'h000820, 32'hDEAD_BEEF, 4'b0000);   // Contention
        rows[5] = make_row(0, 1, 0, 22'h000820, 32'h0BAD_F00D, 4'b0000);
        rows[6] = make_row(1, 0, 1, 22'h000820, 32'h0, 4'b0000);
        rows[7] = make_row(0, 1, 1, 22'h000820, 32'h0, 4'b0000);
        rows[8] = make_row(0, 1, 0, 22'h002010, 32'h5555_AAAA, 4'b1001);
        for (int i = N_DIR; i < N_ROWS; i++) begin
            rand_bits(1, v_port);
            rand_bits(1, v_rd);
            rand_bits(2, v_row);
            rand_bits(3, v_col);
            rand_bits(32, v_data);
            rand_bits(4, v_mask);
            // Small address set so reads hit earlier writes, even column for the burst
            rows[i] = make_row(0, v_port[0], v_rd[0], {11'h0, v_row[1:0], 5'h0, v_col[2:0], 1'b0},
                               v_data, v_mask[3:0]);
        end
    endtask

    // Pin monitor for init order, READ timing, early acks and stray beats
    always @(negedge clk) begin
        if (!rst) begin
            pcmd = {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe};
            if (pcmd != sdram_pkg::NOP) begin
                if (n_cmd == 0 && !(pcmd == sdram_pkg::PRECHARGE && sdram_a[10])) begin
                    $display("ERROR %0t: first command %h is not PRECHARGE all", $time, pcmd);
                    errors++;
                end
                if ((n_cmd == 1 || n_cmd == 2) && pcmd != sdram_pkg::REFRESH) begin
                    $display("ERROR %0t: init command %0d is %h, not REFRESH", $time, n_cmd, pcmd);
                    errors++;
                end
                if (n_cmd == 3) begin
                    if (pcmd != sdram_pkg::LOAD_MODE || sdram_a != MODE_VAL) begin
                        $display("ERROR %0t: bad LOAD_MODE, cmd %h a %h", $time, pcmd, sdram_a);
                        errors++;
                    end
                    mode_done = 1'b1;
                end
                n_cmd++;
            end
            if (pcmd == sdram_pkg::READ) read_cyc[sdram_ba[0]] = cyc;
            if (ack != 2'b00 && !mode_done) begin
                $display("ERROR %0t: ack before LOAD_MODE", $time);
                errors++;
            end
            for (int i = 0; i < 2; i++) begin
                if (dok[i] && !rd_busy[i]) begin
                    $display("ERROR %0t: stray read beat on port %0d", $time, i);
                    errors++;
                end
            end
        end
    end

    task automatic run_op(input row_t r);
        int          p;
        int          beats;
        bit          done;
        logic [31:0] got;
        logic [31:0] exp;
        logic [22:0] key;
        p     = r.port;
        key   = {r.port, r.addr};
        exp   = ref_mem.exists(key) ? ref_mem[key] : 32'h0;
        beats = 0;
        done  = 0;
        got   = 32'h0;
        req[p].rd    = r.rd;
        req[p].wr    = !r.rd;
        req[p].addr  = r.addr;
        req[p].wdata = r.wdata;
        req[p].mask  = r.mask;
        do @(negedge clk); while (!ack[p]);
        rd_busy[p] = r.rd;
        if (!r.rd) ref_mem[key] = merge(exp, r.wdata, r.mask);
        @(negedge clk);    // Bank latched the request on the posedge before
        req[p] = '0;
        while (!done) begin
            if (dok[p]) begin
                if (beats == 0) begin
                    got[15:0] = dout;
                    if (!dst[p]) begin
                        $display("ERROR %0t: port %0d first beat without dst", $time, p);
                        errors++;
                    end
                    if (cyc != read_cyc[p] + `SDRAM_CL + 1) begin
                        $display("ERROR %0t: port %0d first beat %0d cycles after READ",
                                 $time, p, cyc - read_cyc[p]);
                        errors++;
                    end
                end else begin
                    got[31:16] = dout;
                    if (dst[p]) begin
                        $display("ERROR %0t: port %0d dst on a later beat", $time, p);
                        errors++;
                    end
                end
                beats++;
            end else if (dst[p]) begin
                $display("ERROR %0t: port %0d dst without dok", $time, p);
                errors++;
            end
            if (rdy[p]) done = 1;
            else @(negedge clk);
        end
        if (r.rd && (beats != 2 || got != exp)) begin
            $display("ERROR %0t: port %0d read %h beats %0d, expected %h",
                     $time, p, got, beats, exp);
            errors++;
        end
        if (!r.rd && (beats != 0 || sdram_dq != r.wdata[31:16])) begin
            $display("ERROR %0t: port %0d write end, dq %h, expected %h",
                     $time, p, sdram_dq, r.wdata[31:16]);
            errors++;
        end
        @(negedge clk);
        rd_busy[p] = 1'b0;
    endtask

    initial begin
        rst    = 1'b1;
        req[0] = '0;
        req[1] = '0;
        lfsr   = 16'd62;
        build_rows();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // First request is raised while init still owns the bus
        idx = 0;
        while (idx < N_ROWS) begin
            if (rows[idx].pair && idx + 1 < N_ROWS) begin
                fork
                    run_op(rows[idx]);
                    run_op(rows[idx + 1]);
                join
                idx += 2;
            end else begin
                run_op(rows[idx]);
                idx++;
            end
        end
        repeat (4) @(negedge clk);
        $display("Check errors: %0d, model errors: %0d", errors, model_errors);
        if (errors == 0 && model_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
verilog/sdram_pkg.sv
verilog/sdram_init.sv
verilog/sdram_bank.sv
verilog/sdram_cmd_arbiter.sv
verilog/sdram_ctrl.sv
tb/sdram_model.sv
tb/sdram_sva.sv
tb/sdram_tb.sv

// File: verilog/sdram_bank.sv
// Bank machine for one requester port, runs ACTIVE then READ/WRITE with auto-precharge
`timescale 1ns/1ns
`include "sdram_config.svh"

module sdram_bank #(
    parameter logic [1:0] BANK = 2'd0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  sdram_pkg::host_req_t req,
    output logic                 ack,
    output logic                 dst,
    output logic                 dok,
    output logic                 rdy,
    output logic                 dbusy,
    input  logic                 all_dbusy,
    output logic                 br,
    input  logic                 bg,
    output sdram_pkg::bus_cmd_t  cmd
);

    localparam int CNT_W = 4;
    localparam logic [CNT_W-1:0] RCD_LOAD   = CNT_W'(`SDRAM_TRCD - 2);
    localparam logic [CNT_W-1:0] RP_LOAD    = CNT_W'(`SDRAM_TRP - 1);
    localparam logic [CNT_W-1:0] FIRST_BEAT = CNT_W'(`SDRAM_CL);
    localparam logic [CNT_W-1:0] LAST_BEAT  = CNT_W'(`SDRAM_CL + 1);

    typedef enum logic [2:0] {
        IDLE,
        ACT,
        WAIT_RCD,
        RW,
        DATA,
        PRECH
    } state_t;

    state_t                   state;
    logic [CNT_W-1:0]         cnt;
    logic [CNT_W-1:0]         last;
    logic                     beat;     // Second cycle of the READ/WRITE slot
    logic                     is_rd;
    logic [`SDRAM_COL_W-1:0]  col;
    logic [31:0]              wdata;
    logic [3:0]               mask;

    // Reads wait for the registered dout, writes finish with the second beat
    assign last = is_rd ? LAST_BEAT : '0;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
            beat  <= 1'b0;
        end else begin
            case (state)
                IDLE: if (req.rd || req.wr) state <= ACT;
                ACT: begin
                    if (bg) begin
                        state <= WAIT_RCD;
                        cnt   <= RCD_LOAD;
                    end
                end
                WAIT_RCD: begin
                    if (cnt == '0) state <= RW;
                    else cnt <= cnt - 1'b1;
                end
                RW: begin
                    if (bg) begin
                        beat <= ~beat;
                        if (beat) begin
                            state <= DATA;
                            cnt   <= '0;
                        end
                    end
                end
                DATA: begin
                    if (cnt == last) begin
                        state <= PRECH;
                        cnt   <= RP_LOAD;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PRECH: begin
                    if (cnt == '0) state <= IDLE;   // Auto-precharge done
                    else cnt <= cnt - 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Host may drop the request after ack, so keep a copy
    always_ff @(posedge clk) begin
        if (ack) begin
            is_rd <= req.rd;
            col   <= req.addr[`SDRAM_COL_W-1:0];
            wdata <= req.wdata;
            mask  <= req.mask;
        end
    end

    // Data slot only requested while no other burst holds the DQ bus
    assign br    = state == ACT || (state == RW && (beat || !all_dbusy));
    assign ack   = state == ACT && bg;
    assign dbusy = (state == RW && beat) || state == DATA;
    assign dst   = state == DATA && is_rd && cnt == FIRST_BEAT;
    assign dok   = state == DATA && is_rd && (cnt == FIRST_BEAT || cnt == LAST_BEAT);
    assign rdy   = state == DATA && cnt == last;

    always_comb begin
        cmd     = '0;
        cmd.cmd = sdram_pkg::NOP;
        cmd.ba  = BANK;
        case (state)
            ACT: begin
                cmd.cmd = sdram_pkg::ACTIVE;
                cmd.a   = req.addr[`SDRAM_AW-1 -: `SDRAM_ROW_W];
            end
            RW: begin
                if (!beat) begin
                    cmd.cmd                   = is_rd ? sdram_pkg::READ : sdram_pkg::WRITE;
                    cmd.a[`SDRAM_COL_W-1:0]   = col;
                    cmd.a[10]                 = 1'b1;  // Auto-precharge
                end
                if (!is_rd) begin
                    cmd.dq_oe = 1'b1;
                    cmd.dq    = beat ? wdata[31:16] : wdata[15:0];
                    cmd.dqm   = beat ? mask[3:2] : mask[1:0];
                end
            end
            default: cmd.cmd = sdram_pkg::NOP;
        endcase
    end

endmodule

// File: verilog/sdram_cmd_arbiter.sv
// Command bus arbiter with rotating priority, registers the winning command onto the pins
`timescale 1ns/1ns

module sdram_cmd_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                init,
    input  sdram_pkg::bus_cmd_t init_cmd,
    input  logic [1:0]          br,
    input  sdram_pkg::bus_cmd_t bank_cmd0,
    input  sdram_pkg::bus_cmd_t bank_cmd1,
    output logic [1:0]          bg,
    output sdram_pkg::bus_cmd_t pin_cmd
);

    logic                prio;     // Bank favoured on a tie
    logic                locked;
    logic                owner;
    sdram_pkg::bus_cmd_t next;

    always_comb begin
        bg = 2'b00;
        if (!init) begin
            if (locked && br[owner]) bg[owner] = 1'b1;   // Holder keeps the bus
            else if (br == 2'b11)    bg[prio]  = 1'b1;
            else                     bg        = br;
        end
    end

    always_comb begin
        next     = '0;
        next.cmd = sdram_pkg::NOP;
        if (init)       next = init_cmd;
        else if (bg[0]) next = bank_cmd0;
        else if (bg[1]) next = bank_cmd1;
        // Mask only matters on data cycles
        if (!(next.cmd == sdram_pkg::READ || next.cmd == sdram_pkg::WRITE || next.dq_oe))
            next.dqm = 2'b00;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            prio         <= 1'b0;
            locked       <= 1'b0;
            owner        <= 1'b0;
            pin_cmd      <= '0;
            pin_cmd.cmd  <= sdram_pkg::NOP;
        end else begin
            prio    <= ~prio;
            locked  <= |bg;
            owner   <= bg[1];
            pin_cmd <= next;
        end
    end

endmodule

// File: verilog/sdram_ctrl.sv
// Two-port SDR SDRAM controller top, joins init, bank machines and arbiter to the pins
`timescale 1ns/1ns
`include "sdram_config.svh"

module sdram_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  sdram_pkg::host_req_t        req0,
    input  sdram_pkg::host_req_t        req1,
    output logic [1:0]                  ack,
    output logic [1:0]                  dst,
    output logic [1:0]                  dok,
    output logic [1:0]                  rdy,
    output logic [15:0]                 dout,
    inout  wire  [15:0]                 sdram_dq,
    output logic [`SDRAM_ROW_W-1:0]     sdram_a,
    output logic [1:0]                  sdram_ba,
    output logic                        sdram_dqml,
    output logic                        sdram_dqmh,
    output logic                        sdram_ncs,
    output logic                        sdram_nras,
    output logic                        sdram_ncas,
    output logic                        sdram_nwe
);

    sdram_pkg::bus_cmd_t init_cmd;
    sdram_pkg::bus_cmd_t bank_cmd0;
    sdram_pkg::bus_cmd_t bank_cmd1;
    sdram_pkg::bus_cmd_t pin_cmd;
    logic                init;
    logic [1:0]          br;
    logic [1:0]          bg;
    logic [1:0]          dbusy;
    logic                all_dbusy;

    assign all_dbusy = |dbusy;

    assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = pin_cmd.cmd;
    assign sdram_a                  = pin_cmd.a;
    assign sdram_ba                 = pin_cmd.ba;
    assign {sdram_dqmh, sdram_dqml} = pin_cmd.dqm;
    assign sdram_dq = pin_cmd.dq_oe ? pin_cmd.dq : 16'hzzzz;

    // Read beats land here one cycle after the device drives them
    always_ff @(posedge clk) begin
        dout <= sdram_dq;
    end

    sdram_init i_init (
        .clk  (clk),
        .rst  (rst),
        .init (init),
        .cmd  (init_cmd)
    );

    sdram_bank #(.BANK(2'd0)) i_bank0 (
        .clk       (clk),
        .rst       (rst),
        .req       (req0),
        .ack       (ack[0]),
        .dst       (dst[0]),
        .dok       (dok[0]),
        .rdy       (rdy[0]),
        .dbusy     (dbusy[0]),
        .all_dbusy (all_dbusy),
        .br        (br[0]),
        .bg        (bg[0]),
        .cmd       (bank_cmd0)
    );

    sdram_bank #(.BANK(2'd1)) i_bank1 (
        .clk       (clk),
        .rst       (rst),
        .req       (req1),
        .ack       (ack[1]),
        .dst       (dst[1]),
        .dok       (dok[1]),
        .rdy       (rdy[1]),
        .dbusy     (dbusy[1]),
        .all_dbusy (all_dbusy),
        .br        (br[1]),
        .bg        (bg[1]),
        .cmd       (bank_cmd1)
    );

    sdram_cmd_arbiter i_arbiter (
        .clk       (clk),
        .rst       (rst),
        .init      (init),
        .init_cmd  (init_cmd),
        .br        (br),
        .bank_cmd0 (bank_cmd0),
        .bank_cmd1 (bank_cmd1),
        .bg        (bg),
        .pin_cmd   (pin_cmd)
    );

endmodule

// File: verilog/sdram_init.sv
// Power-up sequencer, owns the command bus until the mode register is loaded
`timescale 1ns/1ns
`include "sdram_config.svh"

module sdram_init (
    input  logic                clk,
    input  logic                rst,
    output logic                init,
    output sdram_pkg::bus_cmd_t cmd
);

    localparam int CW = $clog2(`SDRAM_INIT_WAIT + 1);

    // Burst 2, sequential, programmed CAS latency, burst writes
    localparam logic [12:0] MODE = {3'b000, 1'b0, 2'b00, 3'(`SDRAM_CL), 1'b0, 3'b001};

    logic [2:0]    step;   // 0 PRECHARGE, 1-2 REFRESH, 3 LOAD_MODE, 4 tMRD gap
    logic [CW-1:0] cnt;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            init <= 1'b1;
            step <= '0;
            cnt  <= CW'(`SDRAM_INIT_WAIT - 1);
        end else if (init) begin
            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                step <= step + 1'b1;
                case (step)
                    3'd0:       cnt <= CW'(`SDRAM_TRP - 1);
                    3'd1, 3'd2: cnt <= CW'(`SDRAM_INIT_WAIT - 1);   // tRFC
                    3'd3:       cnt <= CW'(1);                      // tMRD
                    default:    init <= 1'b0;   // Released for good
                endcase
            end
        end
    end

    always_comb begin
        cmd     = '0;
        cmd.cmd = sdram_pkg::NOP;
        if (init && cnt == '0) begin
            case (step)
                3'd0: begin
                    cmd.cmd = sdram_pkg::PRECHARGE;
                    cmd.a   = 13'h0400;    // A10 selects all banks
                end
                3'd1, 3'd2: cmd.cmd = sdram_pkg::REFRESH;
                3'd3: begin
                    cmd.cmd = sdram_pkg::LOAD_MODE;
                    cmd.a   = MODE;
                end
                default: cmd.cmd = sdram_pkg::NOP;
            endcase
        end
    end

endmodule

// File: verilog/sdram_pkg.sv
// Command encoding and the request and command bus types shared by the controller blocks
`include "sdram_config.svh"

package sdram_pkg;

    // Bit order is {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        LOAD_MODE = 4'b0000,
        REFRESH   = 4'b0001,
        PRECHARGE = 4'b0010,
        ACTIVE    = 4'b0011,
        WRITE     = 4'b0100,
        READ      = 4'b0101,
        NOP       = 4'b0111
    } sdram_cmd_e;

    // One host request, held until ack
    typedef struct packed {
        logic                   rd;
        logic                   wr;
        logic [`SDRAM_AW-1:0]   addr;
        logic [31:0]            wdata;  // Low beat in 15:0
        logic [3:0]             mask;   // Set bit keeps the old byte
    } host_req_t;

    // Everything that goes onto the SDRAM pins in one cycle
    typedef struct packed {
        sdram_cmd_e                 cmd;
        logic [1:0]                 ba;
        logic [`SDRAM_ROW_W-1:0]    a;
        logic [1:0]                 dqm;    // {dqmh, dqml}
        logic [15:0]                dq;
        logic                       dq_oe;
    } bus_cmd_t;

endpackage
